//--- hw/decode_pkg.sv
`default_nettype none

package decode_pkg;

   localparam int XLEN = 64;
   localparam int LG_PRF = 6;                // room for a larger register file
   localparam int QUEUE_DEPTH = 4;
   localparam int LG_QUEUE = 2;
   localparam int LG_CREDITS = 3;
   localparam logic [LG_CREDITS-1:0] OUT_CREDITS = 3'd4;

   localparam logic CTRL_RUN = 1'b0;
   localparam logic CTRL_SQUASH = 1'b1;      // dropping wrong-path packets

   localparam logic [6:0] OPC_LOAD = 7'h03;
   localparam logic [6:0] OPC_OP_IMM = 7'h13;
   localparam logic [6:0] OPC_AUIPC = 7'h17;
   localparam logic [6:0] OPC_STORE = 7'h23;
   localparam logic [6:0] OPC_OP = 7'h33;
   localparam logic [6:0] OPC_LUI = 7'h37;
   localparam logic [6:0] OPC_BRANCH = 7'h63;
   localparam logic [6:0] OPC_JALR = 7'h67;
   localparam logic [6:0] OPC_JAL = 7'h6f;

   typedef enum logic [5:0] {
      LB, LH, LW, LD, LBU, LHU, LWU,
      SB, SH, SW, SD,
      ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, SRAI, ORI, ANDI,
      ADDU, SUBU, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
      AUIPC, LUI,
      BEQ, BNE, BLT, BGE, BLTU, BGEU,
      J, JAL, JR, JALR, RET,
      NOP, II, FETCH_PF, IRQ
   } uop_op_t;

   typedef struct packed {
      logic [31:0]     insn;
      logic [XLEN-1:0] pc;
      logic            page_fault;
      logic            irq;
   } fetch_pkt_t;

   typedef struct packed {
      uop_op_t           op;
      logic [LG_PRF-1:0] src_a;
      logic              src_a_valid;
      logic [LG_PRF-1:0] src_b;
      logic              src_b_valid;
      logic [LG_PRF-1:0] dst;
      logic              dst_valid;
      logic              is_mem;
      logic              is_store;
      logic              is_int;
      logic              is_cheap_int;
      logic              is_br;
      logic [XLEN-1:0]   imm;          // immediate or pc-relative target
      logic [XLEN-1:0]   pc;
   } uop_t;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
      s_fmt_t s_fmt;
      u_fmt_t u_fmt;
      b_fmt_t b_fmt;
      j_fmt_t j_fmt;
   } insn_t;

endpackage

`default_nettype wire

//--- hw/fetch_queue.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_queue
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   push,
   input  decode_pkg::fetch_pkt_t push_pkt,
   input  logic                   pop,
   output logic                   head_valid,
   output decode_pkg::fetch_pkt_t head_pkt
);

   decode_pkg::fetch_pkt_t mem [decode_pkg::QUEUE_DEPTH];
   logic [decode_pkg::LG_QUEUE-1:0] rd_ptr;
   logic [decode_pkg::LG_QUEUE-1:0] wr_ptr;
   logic [decode_pkg::LG_QUEUE:0] count;

   assign head_valid = count != '0;
   assign head_pkt = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= push_pkt;   // never full, fetch holds the credits
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hw/credit_counter.sv
`timescale 1ns/10ps
`default_nettype none

module credit_counter
(
   input  logic clk,
   input  logic reset,
   input  logic spend,
   input  logic refund,
   output logic has_credit
);

   logic [decode_pkg::LG_CREDITS-1:0] count;   // free rename slots

   assign has_credit = count != '0;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count <= decode_pkg::OUT_CREDITS;
      end
      else
      begin
         case ({spend, refund})
            2'b10: count <= count - 1'b1;
            2'b01: count <= count + 1'b1;
            default: count <= count;          // both or neither cancel
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/decode_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module decode_ctrl
(
   input  logic clk,
   input  logic reset,
   input  logic head_valid,
   input  logic has_credit,
   input  logic traps,
   input  logic redirect,
   output logic issue,
   output logic discard
);

   logic state;

   // head leaves the queue by one of these two, never both
   assign issue = (state == decode_pkg::CTRL_RUN) && head_valid && has_credit;
   assign discard = (state == decode_pkg::CTRL_SQUASH) && head_valid;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= decode_pkg::CTRL_RUN;
      end
      else
      begin
         case (state)
            decode_pkg::CTRL_RUN:
            begin
               if (issue && traps)
                  state <= decode_pkg::CTRL_SQUASH;   // fault or irq sent
            end
            decode_pkg::CTRL_SQUASH:
            begin
               if (redirect)
                  state <= decode_pkg::CTRL_RUN;
            end
            default:
            begin
               state <= decode_pkg::CTRL_RUN;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/uop_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module uop_decoder
(
   input  logic                   clk,
   input  logic                   reset,
   input  decode_pkg::fetch_pkt_t head_pkt,
   input  logic                   issue,
   output logic                   traps,
   output logic                   uop_valid,
   output decode_pkg::uop_t       uop
);

   decode_pkg::insn_t insn;
   decode_pkg::uop_t next_uop;
   logic [decode_pkg::LG_PRF-1:0] rd;
   logic [decode_pkg::LG_PRF-1:0] rs1;
   logic [decode_pkg::LG_PRF-1:0] rs2;
   logic [decode_pkg::XLEN-1:0] i_imm;
   logic [decode_pkg::XLEN-1:0] s_imm;
   logic [decode_pkg::XLEN-1:0] u_imm;
   logic [decode_pkg::XLEN-1:0] b_imm;
   logic [decode_pkg::XLEN-1:0] j_imm;
   logic [decode_pkg::XLEN-1:0] pc_ofs;
   logic [decode_pkg::XLEN-1:0] pc_target;
   logic int_result;

   assign insn = head_pkt.insn;
   assign traps = head_pkt.page_fault | head_pkt.irq;
   assign rd = {{(decode_pkg::LG_PRF-5){1'b0}}, insn.r_fmt.rd};
   assign rs1 = {{(decode_pkg::LG_PRF-5){1'b0}}, insn.r_fmt.rs1};
   assign rs2 = {{(decode_pkg::LG_PRF-5){1'b0}}, insn.r_fmt.rs2};

   assign i_imm = {{(decode_pkg::XLEN-12){insn.i_fmt.imm_11_0[11]}}, insn.i_fmt.imm_11_0};
   assign s_imm = {{(decode_pkg::XLEN-12){insn.s_fmt.imm_11_5[6]}},
                   insn.s_fmt.imm_11_5, insn.s_fmt.imm_4_0};
   assign u_imm = {{(decode_pkg::XLEN-32){insn.u_fmt.imm_31_12[19]}},
                   insn.u_fmt.imm_31_12, 12'd0};
   assign b_imm = {{(decode_pkg::XLEN-13){insn.b_fmt.imm_12}}, insn.b_fmt.imm_12,
                   insn.b_fmt.imm_11, insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
   assign j_imm = {{(decode_pkg::XLEN-21){insn.j_fmt.imm_20}}, insn.j_fmt.imm_20,
                   insn.j_fmt.imm_19_12, insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};

   always_comb
   begin
      case (insn.r_fmt.opcode)
         decode_pkg::OPC_AUIPC: pc_ofs = u_imm;
         decode_pkg::OPC_BRANCH: pc_ofs = b_imm;
         default: pc_ofs = j_imm;
      endcase
   end

   assign pc_target = head_pkt.pc + pc_ofs;   // shared by auipc, branches, jal

   always_comb
   begin
      next_uop = '0;
      next_uop.pc = head_pkt.pc;
      next_uop.op = head_pkt.page_fault ? decode_pkg::FETCH_PF :
                    (head_pkt.irq ? decode_pkg::IRQ : decode_pkg::II);
      int_result = 1'b0;
      if (!traps)
      begin
         case (insn.r_fmt.opcode)
            decode_pkg::OPC_LOAD:
            begin
               next_uop.dst = rd;
               next_uop.dst_valid = rd != '0;   // op kept for x0
               next_uop.src_a = rs1;
               next_uop.src_a_valid = 1'b1;
               next_uop.is_mem = 1'b1;
               next_uop.imm = i_imm;
               case (insn.i_fmt.funct3)
                  3'd0: next_uop.op = decode_pkg::LB;
                  3'd1: next_uop.op = decode_pkg::LH;
                  3'd2: next_uop.op = decode_pkg::LW;
                  3'd3: next_uop.op = decode_pkg::LD;
                  3'd4: next_uop.op = decode_pkg::LBU;
                  3'd5: next_uop.op = decode_pkg::LHU;
                  3'd6: next_uop.op = decode_pkg::LWU;
                  default: next_uop.op = decode_pkg::II;
               endcase
            end
            decode_pkg::OPC_OP_IMM:
            begin
               int_result = 1'b1;
               next_uop.dst = rd;
               next_uop.dst_valid = rd != '0;
               next_uop.src_a = rs1;
               next_uop.src_a_valid = 1'b1;
               next_uop.is_int = 1'b1;
               next_uop.imm = i_imm;
               case (insn.i_fmt.funct3)
                  3'd0: next_uop.op = decode_pkg::ADDI;
                  3'd1: next_uop.op = decode_pkg::SLLI;
                  3'd2: next_uop.op = decode_pkg::SLTI;
                  3'd3: next_uop.op = decode_pkg::SLTIU;
                  3'd4: next_uop.op = decode_pkg::XORI;
                  3'd5:
                  begin
                     case (insn.i_fmt.imm_11_0[11:6])   // funct6 picks the shift
                        6'h00: next_uop.op = decode_pkg::SRLI;
                        6'h10: next_uop.op = decode_pkg::SRAI;
                        default: next_uop.op = decode_pkg::II;
                     endcase
                  end
                  3'd6: next_uop.op = decode_pkg::ORI;
                  default: next_uop.op = decode_pkg::ANDI;
               endcase
               next_uop.is_cheap_int = next_uop.op != decode_pkg::II;
            end
            decode_pkg::OPC_AUIPC, decode_pkg::OPC_LUI:
            begin
               int_result = 1'b1;
               next_uop.dst = rd;
               next_uop.dst_valid = rd != '0;
               next_uop.is_int = 1'b1;
               next_uop.is_cheap_int = 1'b1;
               if (insn.u_fmt.opcode == decode_pkg::OPC_LUI)
               begin
                  next_uop.op = decode_pkg::LUI;
                  next_uop.imm = u_imm;
               end
               else
               begin
                  next_uop.op = decode_pkg::AUIPC;
                  next_uop.imm = pc_target;
               end
            end
            decode_pkg::OPC_STORE:
            begin
               next_uop.src_a = rs1;
               next_uop.src_a_valid = 1'b1;
               next_uop.src_b = rs2;
               next_uop.src_b_valid = 1'b1;
               next_uop.is_mem = 1'b1;
               next_uop.is_store = 1'b1;
               next_uop.imm = s_imm;
               case (insn.s_fmt.funct3)
                  3'd0: next_uop.op = decode_pkg::SB;
                  3'd1: next_uop.op = decode_pkg::SH;
                  3'd2: next_uop.op = decode_pkg::SW;
                  3'd3: next_uop.op = decode_pkg::SD;
                  default: next_uop.op = decode_pkg::II;
               endcase
            end
            decode_pkg::OPC_OP:
            begin
               int_result = 1'b1;
               next_uop.dst = rd;
               next_uop.dst_valid = rd != '0;
               next_uop.src_a = rs1;
               next_uop.src_a_valid = 1'b1;
               next_uop.src_b = rs2;
               next_uop.src_b_valid = 1'b1;
               next_uop.is_int = 1'b1;   // never cheap
               case ({insn.r_fmt.funct7, insn.r_fmt.funct3})
                  {7'h00, 3'd0}: next_uop.op = decode_pkg::ADDU;
                  {7'h20, 3'd0}: next_uop.op = decode_pkg::SUBU;
                  {7'h00, 3'd1}: next_uop.op = decode_pkg::SLL;
                  {7'h00, 3'd2}: next_uop.op = decode_pkg::SLT;
                  {7'h00, 3'd3}: next_uop.op = decode_pkg::SLTU;
                  {7'h00, 3'd4}: next_uop.op = decode_pkg::XOR;
                  {7'h00, 3'd5}: next_uop.op = decode_pkg::SRL;
                  {7'h20, 3'd5}: next_uop.op = decode_pkg::SRA;
                  {7'h00, 3'd6}: next_uop.op = decode_pkg::OR;
                  {7'h00, 3'd7}: next_uop.op = decode_pkg::AND;
                  default: next_uop.op = decode_pkg::II;
               endcase
            end
            decode_pkg::OPC_BRANCH:
            begin
               next_uop.src_a = rs1;
               next_uop.src_a_valid = 1'b1;
               next_uop.src_b = rs2;
               next_uop.src_b_valid = 1'b1;
               next_uop.is_int = 1'b1;
               next_uop.is_br = 1'b1;
               next_uop.imm = pc_target;
               case (insn.b_fmt.funct3)
                  3'd0: next_uop.op = decode_pkg::BEQ;
                  3'd1: next_uop.op = decode_pkg::BNE;
                  3'd4: next_uop.op = decode_pkg::BLT;
                  3'd5: next_uop.op = decode_pkg::BGE;
                  3'd6: next_uop.op = decode_pkg::BLTU;
                  3'd7: next_uop.op = decode_pkg::BGEU;
                  default: next_uop.op = decode_pkg::II;
               endcase
            end
            decode_pkg::OPC_JALR:
            begin
               next_uop.src_a = rs1;
               next_uop.src_a_valid = 1'b1;
               next_uop.is_int = 1'b1;
               next_uop.is_cheap_int = 1'b1;
               next_uop.is_br = 1'b1;
               next_uop.imm = i_imm;
               if (rd == '0)
                  next_uop.op = (rs1 == 'd1 || rs1 == 'd5) ? decode_pkg::RET : decode_pkg::JR;
               else
               begin
                  next_uop.op = decode_pkg::JALR;
                  next_uop.dst = rd;
                  next_uop.dst_valid = 1'b1;
               end
            end
            decode_pkg::OPC_JAL:
            begin
               next_uop.is_int = 1'b1;
               next_uop.is_br = 1'b1;
               next_uop.imm = pc_target;
               if (rd == '0)
                  next_uop.op = decode_pkg::J;
               else
               begin
                  next_uop.op = decode_pkg::JAL;
                  next_uop.dst = rd;
                  next_uop.dst_valid = 1'b1;
                  next_uop.is_cheap_int = 1'b1;   // link write only
               end
            end
            default:
            begin
               next_uop.op = decode_pkg::II;
            end
         endcase
         if (int_result && rd == '0 && next_uop.op != decode_pkg::II)
            next_uop.op = decode_pkg::NOP;   // result dropped at x0
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         uop_valid <= 1'b0;
      else
         uop_valid <= issue;   // one cycle per issue
   end

   always_ff @(posedge clk)
   begin
      if (issue)
         uop <= next_uop;
   end

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   fetch_valid,
   input  decode_pkg::fetch_pkt_t fetch_pkt,
   input  logic                   uop_credit,
   input  logic                   redirect,
   output logic                   fetch_credit,
   output logic                   uop_valid,
   output decode_pkg::uop_t       uop
);

   logic head_valid;
   decode_pkg::fetch_pkt_t head_pkt;
   logic has_credit;
   logic traps;
   logic issue;
   logic discard;
   logic pop;

   assign pop = issue | discard;
   assign fetch_credit = pop;   // each slot freed goes back to fetch

   fetch_queue queue_i
   (
      .clk(clk),
      .reset(reset),
      .push(fetch_valid),
      .push_pkt(fetch_pkt),
      .pop(pop),
      .head_valid(head_valid),
      .head_pkt(head_pkt)
   );

   credit_counter credit_i
   (
      .clk(clk),
      .reset(reset),
      .spend(issue),
      .refund(uop_credit),
      .has_credit(has_credit)
   );

   decode_ctrl ctrl_i
   (
      .clk(clk),
      .reset(reset),
      .head_valid(head_valid),
      .has_credit(has_credit),
      .traps(traps),
      .redirect(redirect),
      .issue(issue),
      .discard(discard)
   );

   uop_decoder decoder_i
   (
      .clk(clk),
      .reset(reset),
      .head_pkt(head_pkt),
      .issue(issue),
      .traps(traps),
      .uop_valid(uop_valid),
      .uop(uop)
   );

endmodule

`default_nettype wire

//--- testbench/decode_stage_chk.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage_chk
(
   input logic clk,
   input logic reset,
   input logic issue,
   input logic discard,
   input logic has_credit,
   input logic traps,
   input logic redirect,
   input logic uop_credit,
   input logic uop_valid,
   input logic fetch_credit
);

   logic [3:0] model_count;   // mirror of the rename credits
   logic squashing;           // trap sent, redirect not yet seen

   always_ff @(posedge clk)
   begin
      if (reset)
         model_count <= 4'(decode_pkg::OUT_CREDITS);
      else
         model_count <= model_count - 4'(issue) + 4'(uop_credit);
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         squashing <= 1'b0;
      else if (issue && traps)
         squashing <= 1'b1;
      else if (redirect)
         squashing <= 1'b0;
   end

   a_credit_mirror: assert property (@(posedge clk) disable iff (reset)
      has_credit == (model_count != '0))
      else $error("credit flag disagrees with the free slot count");

   a_valid_credit: assert property (@(posedge clk) disable iff (reset)
      uop_valid |-> $past(issue && model_count != '0))
      else $error("uop_valid without a credited issue");

   a_count_max: assert property (@(posedge clk) disable iff (reset)
      model_count <= 4'(decode_pkg::OUT_CREDITS)) else $error("rename credits above reset count");

   a_squash: assert property (@(posedge clk) disable iff (reset)
      squashing |=> !uop_valid) else $error("micro-op from a discarded head");

   a_discard: assert property (@(posedge clk) disable iff (reset)
      discard |-> squashing) else $error("head discarded outside the wrong path");

   a_reset_quiet: assert property (@(posedge clk)
      reset |=> (!uop_valid && !fetch_credit)) else $error("outputs active during reset");

endmodule

bind decode_stage decode_stage_chk chk_i
(
   .clk(clk),
   .reset(reset),
   .issue(issue),
   .discard(discard),
   .has_credit(has_credit),
   .traps(traps),
   .redirect(redirect),
   .uop_credit(uop_credit),
   .uop_valid(uop_valid),
   .fetch_credit(fetch_credit)
);

`default_nettype wire

//--- testbench/decode_stage_tb.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage_tb;

   localparam int NUM_ROWS = 28;
   localparam int HOLD_CYCLES = 60;

   typedef struct {
      string                name;
      logic [31:0]          insn;
      logic [63:0]          pc;
      logic                 pf;
      logic                 irq;
      logic                 squashed;   // sent in the shadow of a trap
      decode_pkg::uop_op_t  op;
      logic [5:0]           dst;
      logic                 dv;
      logic [5:0]           sa;
      logic                 sav;
      logic [5:0]           sb;
      logic                 sbv;
      logic [4:0]           flags;      // mem, store, int, cheap, br
      logic [63:0]          imm;
   } row_t;

   logic clk;
   logic reset;
   logic fetch_valid;
   decode_pkg::fetch_pkt_t fetch_pkt;
   logic uop_credit;
   logic redirect;
   logic fetch_credit;
   logic uop_valid;
   decode_pkg::uop_t uop;

   row_t rows [NUM_ROWS];
   int n_rows = 0;
   int exp_q [$];
   int credits = decode_pkg::QUEUE_DEPTH;   // fetch side credits
   int sent_total = 0;
   int returned_total = 0;
   int outstanding = 0;                      // micro-ops not yet credited back
   int received = 0;
   int hold_cycles = 0;
   logic hold = 1'b1;
   logic need_redirect = 1'b0;
   logic [31:0] fetch_seed = 32'h8f5a6992;
   logic [31:0] rename_seed;

   decode_stage decode_stage_i
   (
      .clk(clk),
      .reset(reset),
      .fetch_valid(fetch_valid),
      .fetch_pkt(fetch_pkt),
      .uop_credit(uop_credit),
      .redirect(redirect),
      .fetch_credit(fetch_credit),
      .uop_valid(uop_valid),
      .uop(uop)
   );

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic add_row(input string name, input logic [31:0] insn, input logic [63:0] pc,
                          input logic pf, input logic irq, input logic sq,
                          input decode_pkg::uop_op_t op, input logic [5:0] dst, input logic dv,
                          input logic [5:0] sa, input logic sav, input logic [5:0] sb,
                          input logic sbv, input logic [4:0] flags, input logic [63:0] imm);
      rows[n_rows] = '{name, insn, pc, pf, irq, sq, op, dst, dv, sa, sav, sb, sbv, flags, imm};
      n_rows++;
   endtask

   task automatic load_table();
      add_row("ld_neg", 32'hff853283, 64'h1000, 0, 0, 0, decode_pkg::LD,
              6'd5, 1, 6'd10, 1, 6'd0, 0, 5'b10000, 64'hffff_ffff_ffff_fff8);
      add_row("lbu_x0", 32'h00414003, 64'h1004, 0, 0, 0, decode_pkg::LBU,
              6'd0, 0, 6'd2, 1, 6'd0, 0, 5'b10000, 64'h4);
      add_row("sw_neg", 32'hfe71ae23, 64'h1008, 0, 0, 0, decode_pkg::SW,
              6'd0, 0, 6'd3, 1, 6'd7, 1, 5'b11000, 64'hffff_ffff_ffff_fffc);
      add_row("addi_neg", 32'hfff10093, 64'h100c, 0, 0, 0, decode_pkg::ADDI,
              6'd1, 1, 6'd2, 1, 6'd0, 0, 5'b00110, 64'hffff_ffff_ffff_ffff);
      add_row("srai", 32'h40325213, 64'h1010, 0, 0, 0, decode_pkg::SRAI,
              6'd4, 1, 6'd4, 1, 6'd0, 0, 5'b00110, 64'h403);
      add_row("sub_x0", 32'h40208033, 64'h1014, 0, 0, 0, decode_pkg::NOP,
              6'd0, 0, 6'd1, 1, 6'd2, 1, 5'b00100, 64'h0);
      add_row("addi_x0", 32'h00728013, 64'h1018, 0, 0, 0, decode_pkg::NOP,
              6'd0, 0, 6'd5, 1, 6'd0, 0, 5'b00110, 64'h7);
      add_row("xor", 32'h00b544b3, 64'h101c, 0, 0, 0, decode_pkg::XOR,
              6'd9, 1, 6'd10, 1, 6'd11, 1, 5'b00100, 64'h0);
      add_row("lui_neg", 32'h80000337, 64'h1020, 0, 0, 0, decode_pkg::LUI,
              6'd6, 1, 6'd0, 0, 6'd0, 0, 5'b00110, 64'hffff_ffff_8000_0000);
      add_row("auipc", 32'h00001417, 64'h2000, 0, 0, 0, decode_pkg::AUIPC,
              6'd8, 1, 6'd0, 0, 6'd0, 0, 5'b00110, 64'h3000);
      add_row("lui_x0", 32'h00005037, 64'h2004, 0, 0, 0, decode_pkg::NOP,
              6'd0, 0, 6'd0, 0, 6'd0, 0, 5'b00110, 64'h5000);
      add_row("beq_back", 32'hfe2088e3, 64'h4000, 0, 0, 0, decode_pkg::BEQ,
              6'd0, 0, 6'd1, 1, 6'd2, 1, 5'b00101, 64'h3ff0);
      add_row("bgeu_fwd", 32'h0062f463, 64'h4100, 0, 0, 0, decode_pkg::BGEU,
              6'd0, 0, 6'd5, 1, 6'd6, 1, 5'b00101, 64'h4108);
      add_row("jal_link", 32'h001000ef, 64'h5000, 0, 0, 0, decode_pkg::JAL,
              6'd1, 1, 6'd0, 0, 6'd0, 0, 5'b00111, 64'h5800);
      add_row("j_back", 32'hffdff06f, 64'h5100, 0, 0, 0, decode_pkg::J,
              6'd0, 0, 6'd0, 0, 6'd0, 0, 5'b00101, 64'h50fc);
      add_row("ret", 32'h00008067, 64'h5104, 0, 0, 0, decode_pkg::RET,
              6'd0, 0, 6'd1, 1, 6'd0, 0, 5'b00111, 64'h0);
      add_row("jr", 32'h00030067, 64'h5108, 0, 0, 0, decode_pkg::JR,
              6'd0, 0, 6'd6, 1, 6'd0, 0, 5'b00111, 64'h0);
      add_row("jalr", 32'h00c280e7, 64'h510c, 0, 0, 0, decode_pkg::JALR,
              6'd1, 1, 6'd5, 1, 6'd0, 0, 5'b00111, 64'hc);
      add_row("illegal", 32'h0000007f, 64'h5110, 0, 0, 0, decode_pkg::II,
              6'd0, 0, 6'd0, 0, 6'd0, 0, 5'b00000, 64'h0);
      add_row("page_fault", 32'h00000013, 64'h6000, 1, 0, 0, decode_pkg::FETCH_PF,
              6'd0, 0, 6'd0, 0, 6'd0, 0, 5'b00000, 64'h0);
      add_row("shadow_a", 32'h00100093, 64'h6004, 0, 0, 1, decode_pkg::II,
              6'd0, 0, 6'd0, 0, 6'd0, 0, 5'b00000, 64'h0);
      add_row("shadow_b", 32'h00b544b3, 64'h6008, 0, 0, 1, decode_pkg::II,
              6'd0, 0, 6'd0, 0, 6'd0, 0, 5'b00000, 64'h0);
      add_row("addi_after", 32'h00500193, 64'h7000, 0, 0, 0, decode_pkg::ADDI,
              6'd3, 1, 6'd0, 1, 6'd0, 0, 5'b00110, 64'h5);
      add_row("irq", 32'h00000013, 64'h7004, 0, 1, 0, decode_pkg::IRQ,
              6'd0, 0, 6'd0, 0, 6'd0, 0, 5'b00000, 64'h0);
      add_row("ori_after", 32'h7ff16113, 64'h8000, 0, 0, 0, decode_pkg::ORI,
              6'd2, 1, 6'd2, 1, 6'd0, 0, 5'b00110, 64'h7ff);
      add_row("pf_and_irq", 32'h00000013, 64'h8004, 1, 1, 0, decode_pkg::FETCH_PF,
              6'd0, 0, 6'd0, 0, 6'd0, 0, 5'b00000, 64'h0);
      add_row("shadow_c", 32'h00c280e7, 64'h8008, 0, 0, 1, decode_pkg::II,
              6'd0, 0, 6'd0, 0, 6'd0, 0, 5'b00000, 64'h0);
      add_row("sd_after", 32'h00113823, 64'h9000, 0, 0, 0, decode_pkg::SD,
              6'd0, 0, 6'd2, 1, 6'd1, 1, 5'b11000, 64'h10);
   endtask

   task automatic check_val(input string row, input string field,
                            input logic [63:0] exp, input logic [63:0] act);
      assert (exp === act)
      else
         report_fail($sformatf("mismatch %s %s expected %h actual %h", row, field, exp, act));
   endtask

   task automatic compare_uop();
      row_t r;
      assert (exp_q.size() != 0)
      else
         report_fail("a micro-op came out while none was expected");
      r = rows[exp_q.pop_front()];
      check_val(r.name, "op", 64'(r.op), 64'(uop.op));
      check_val(r.name, "dst", 64'(r.dst), 64'(uop.dst));
      check_val(r.name, "dst_valid", 64'(r.dv), 64'(uop.dst_valid));
      check_val(r.name, "src_a", 64'(r.sa), 64'(uop.src_a));
      check_val(r.name, "src_a_valid", 64'(r.sav), 64'(uop.src_a_valid));
      check_val(r.name, "src_b", 64'(r.sb), 64'(uop.src_b));
      check_val(r.name, "src_b_valid", 64'(r.sbv), 64'(uop.src_b_valid));
      check_val(r.name, "flags", 64'(r.flags), 64'({uop.is_mem, uop.is_store, uop.is_int,
                                                    uop.is_cheap_int, uop.is_br}));
      check_val(r.name, "imm", r.imm, uop.imm);
      check_val(r.name, "pc", r.pc, uop.pc);
   endtask

   // one cycle of the fetch model
   task automatic step();
      @(posedge clk);
      fetch_valid <= 1'b0;
      redirect <= 1'b0;
      if (fetch_credit)
      begin
         credits++;
         returned_total++;
         assert (credits <= decode_pkg::QUEUE_DEPTH)
         else
            report_fail("fetch got back more credits than it ever held");
      end
   endtask

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      #(NUM_ROWS * 200 * 4);
      report_fail("timeout, the decode stage stopped producing micro-ops");
   end

   // rename model with scoreboard
   always @(posedge clk)
   begin
      if (reset)
      begin
         uop_credit <= 1'b0;
         rename_seed = lcg(32'h8f5a6992);
      end
      else
      begin
         uop_credit <= 1'b0;
         if (uop_valid)
         begin
            assert (outstanding < int'(decode_pkg::OUT_CREDITS))
            else
               report_fail("more micro-ops in flight than rename slots");
            outstanding++;
            received++;
            compare_uop();
         end
         if (hold)
         begin
            hold_cycles++;
            if (hold_cycles == HOLD_CYCLES)
            begin
               assert (received == int'(decode_pkg::OUT_CREDITS))
               else
                  report_fail($sformatf("%0d micro-ops came out while credits were held",
                                        received));
               hold = 1'b0;
            end
         end
         else if (outstanding != 0)
         begin
            rename_seed = lcg(rename_seed);
            if (rename_seed[21])   // random return delay
            begin
               uop_credit <= 1'b1;
               outstanding--;
            end
         end
      end
   end

   initial
   begin
      reset = 1'b1;
      fetch_valid = 1'b0;
      fetch_pkt = '0;
      redirect = 1'b0;
      uop_credit = 1'b0;
      load_table();
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < NUM_ROWS; i++)
      begin
         if (need_redirect && !rows[i].squashed)
         begin
            while (credits != decode_pkg::QUEUE_DEPTH)
               step();   // wrong-path packets all drained
            redirect <= 1'b1;
            step();
            need_redirect = 1'b0;
         end
         step();
         fetch_seed = lcg(fetch_seed);
         while (credits == 0 || fetch_seed[20])
         begin
            step();
            fetch_seed = lcg(fetch_seed);
         end
         fetch_valid <= 1'b1;
         fetch_pkt <= '{rows[i].insn, rows[i].pc, rows[i].pf, rows[i].irq};
         credits--;
         sent_total++;
         if (!rows[i].squashed)
            exp_q.push_back(i);
         if (rows[i].pf || rows[i].irq)
            need_redirect = 1'b1;
      end
      step();
      while (exp_q.size() != 0 || hold)
         step();
      repeat (10) step();   // catch any stray micro-op
      assert (returned_total == sent_total)
      else
         report_fail($sformatf("mismatch fetch_credit_total expected %0d actual %0d",
                               sent_total, returned_total));
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
hw/decode_pkg.sv
hw/fetch_queue.sv
hw/credit_counter.sv
hw/decode_ctrl.sv
hw/uop_decoder.sv
hw/decode_stage.sv
testbench/decode_stage_chk.sv
testbench/decode_stage_tb.sv

//--- Makefile
TOP = decode_stage_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
